//--- vlog.f
rtlinf_pkg.sv
tile_mem.sv
stream_reader.sv
operand_join.sv
mac_lane.sv
lane_drain.sv
clip_writer.sv
rtlinf_top.sv
rtlinf_checker.sv
tb_rtlinf.sv

//--- run.sh
#!/bin/sh
# build and run the rtlinf testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_rtlinf -f vlog.f -o tb_rtlinf
out=$(./obj_dir/tb_rtlinf +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "TESTS PASSED"

//--- tb_rtlinf.sv
// testbench for rtlinf_top
// loads both memories, runs directed and random configs and compares
// every write against a reference model of the accelerator
module tb_rtlinf;

  localparam int NUM_TESTS = 5;

  logic                                   clk;
  logic                                   rst_n;
  logic                                   configure;
  rtlinf_pkg::rtlinf_cfg_t                cfg;
  rtlinf_pkg::mem_load_t                  load;
  logic                                   write_valid;
  logic [rtlinf_pkg::LOG_MAX_ADDRESS-1:0] write_addr;
  logic [rtlinf_pkg::ACT_WORD_WIDTH-1:0]  write_data;
  logic                                   done;

  logic [rtlinf_pkg::ACT_WORD_WIDTH-1:0]    act_img [rtlinf_pkg::NUM_ADDRESSES];
  logic [rtlinf_pkg::WEIGHT_WORD_WIDTH-1:0] wt_img  [rtlinf_pkg::NUM_ADDRESSES];
  rtlinf_pkg::rtlinf_cfg_t                  tests   [NUM_TESTS];
  logic [rtlinf_pkg::LOG_MAX_ADDRESS-1:0]   exp_addr_q [$];
  logic [rtlinf_pkg::ACT_WORD_WIDTH-1:0]    exp_data_q [$];
  int          value_errs;
  int          proto_errs;
  int          chk_errs;
  int          done_cnt;
  int          active_cycles;
  int          cycle_limit;
  logic        busy;
  logic        run_over;
  int unsigned seed_ret;

  rtlinf_top rtlinf_top_inst (
    .clk(clk), .rst_n(rst_n), .configure(configure), .cfg(cfg), .load(load),
    .write_valid(write_valid), .write_addr(write_addr), .write_data(write_data),
    .done(done)
  );

  always #10 clk = ~clk;

  // expected word for lane `lane` of iteration `iter`
  function automatic logic [rtlinf_pkg::ACT_WORD_WIDTH-1:0] expected_word(
      rtlinf_pkg::rtlinf_cfg_t c, int iter, int lane);
    logic signed [rtlinf_pkg::ACC_WIDTH-1:0]  acc;
    logic signed [rtlinf_pkg::ACC_WIDTH-1:0]  prod;
    logic signed [rtlinf_pkg::DATA_WIDTH-1:0] a;
    logic signed [rtlinf_pkg::DATA_WIDTH-1:0] w;
    logic signed [rtlinf_pkg::DATA_WIDTH-1:0] lo;
    logic signed [rtlinf_pkg::DATA_WIDTH-1:0] hi;
    logic [rtlinf_pkg::LOG_MAX_ADDRESS-1:0]   ra;
    logic [rtlinf_pkg::ACT_WORD_WIDTH-1:0]    word;
    lo = c.min_clip;
    hi = c.max_clip;
    for (int g = 0; g < rtlinf_pkg::GROUP_SIZE; g++) begin
      acc = '0;
      for (int r = 0; r < int'(c.num_reads_per_iter); r++) begin
        ra   = 8'(int'(c.read_address) + iter * int'(c.num_reads_per_iter) + r);
        a    = act_img[ra][g*8 +: 8];
        w    = wt_img[ra][lane*8 +: 8];
        prod = a * w;
        acc  = acc + prod;  // 16 bit wrap
      end
      if (acc > hi) begin
        word[g*8 +: 8] = hi;
      end else if (acc < lo) begin
        word[g*8 +: 8] = lo;
      end else begin
        word[g*8 +: 8] = acc[7:0];
      end
    end
    return word;
  endfunction

  function automatic rtlinf_pkg::rtlinf_cfg_t make_cfg(int iters, int reads, int ra, int wa,
                                                       int lo, int hi);
    rtlinf_pkg::rtlinf_cfg_t c;
    c.num_iters          = 8'(iters);
    c.num_reads_per_iter = 8'(reads);
    c.read_address       = 8'(ra);
    c.write_address      = 8'(wa);
    c.min_clip           = 8'(lo);
    c.max_clip           = 8'(hi);
    return c;
  endfunction

  // low half of each memory holds small values so sums stay unclipped
  task automatic load_memories();
    logic [rtlinf_pkg::WEIGHT_WORD_WIDTH-1:0] word;
    for (int sel = 0; sel < 2; sel++) begin
      for (int a = 0; a < rtlinf_pkg::NUM_ADDRESSES; a++) begin
        for (int b = 0; b < rtlinf_pkg::NUM_LANES; b++) begin
          word[b*8 +: 8] = (a < 128) ? 8'($urandom % 8) - 8'd4 : 8'($urandom);
        end
        if (sel == 0) begin
          act_img[a] = word[rtlinf_pkg::ACT_WORD_WIDTH-1:0];
        end else begin
          wt_img[a] = word;
        end
        @(posedge clk);
        load <= '{load_en: 1'b1, load_weight: (sel == 1), load_addr: 8'(a), load_data: word};
      end
    end
    @(posedge clk);
    load <= '0;
  endtask

  task automatic run_test(input rtlinf_pkg::rtlinf_cfg_t c);
    for (int i = 0; i < int'(c.num_iters); i++) begin
      for (int l = 0; l < rtlinf_pkg::NUM_LANES; l++) begin
        exp_addr_q.push_back(8'(int'(c.write_address) + i * rtlinf_pkg::NUM_LANES + l));
        exp_data_q.push_back(expected_word(c, i, l));
      end
    end
    done_cnt = 0;
    run_over = 1'b0;
    @(posedge clk);
    configure <= 1'b1;
    cfg       <= c;
    busy      <= 1'b1;
    @(posedge clk);
    configure <= 1'b0;
    while (!run_over) @(posedge clk);
    busy <= 1'b0;
    repeat (6) @(posedge clk);  // catches stray writes
    assert (done_cnt == 1) else begin
      $display("done pulsed %0d times in one run instead of once", done_cnt);
      proto_errs++;
    end
  endtask

  always @(negedge clk) begin : compare_writes
    logic [rtlinf_pkg::LOG_MAX_ADDRESS-1:0] exp_a;
    logic [rtlinf_pkg::ACT_WORD_WIDTH-1:0]  exp_d;
    if (rst_n && write_valid) begin
      if (exp_addr_q.size() == 0) begin
        $display("write at time %0t to address %0h with nothing expected", $time, write_addr);
        proto_errs++;
      end else begin
        exp_a = exp_addr_q.pop_front();
        exp_d = exp_data_q.pop_front();
        assert (write_addr == exp_a) else begin
          $display("[FAIL] %0t write_addr expected %0h got %0h", $time, exp_a, write_addr);
          value_errs++;
        end
        assert (write_data == exp_d) else begin
          $display("[FAIL] %0t write_data expected %0h got %0h", $time, exp_d, write_data);
          value_errs++;
        end
        if (done) begin
          done_cnt++;
        end
        if (exp_addr_q.size() == 0) begin
          run_over = 1'b1;
          assert (done) else begin
            $display("done missing on the last write at time %0t", $time);
            proto_errs++;
          end
        end else begin
          assert (!done) else begin
            $display("done raised before the last write at time %0t", $time);
            proto_errs++;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    if (busy) begin
      active_cycles <= active_cycles + 1;
      if (active_cycles >= cycle_limit) begin
        $display("timeout, a run did not finish within %0d cycles", cycle_limit);
        $display("TESTS FAILED");
        $finish;
      end
    end
  end

  initial begin
    seed_ret      = $urandom(32'h3fd1);
    clk           = 1'b0;
    rst_n         = 1'b0;
    configure     = 1'b0;
    cfg           = '0;
    load          = '0;
    busy          = 1'b0;
    run_over      = 1'b0;
    value_errs    = 0;
    proto_errs    = 0;
    done_cnt      = 0;
    active_cycles = 0;
    tests[0] = make_cfg(1, 1, 'h10, 'h00, -128, 127);
    tests[1] = make_cfg(1, 5, 'h20, 'h10, -128, 127);
    tests[2] = make_cfg(3, 2, 'h40, 'h20, -128, 127);
    tests[3] = make_cfg(2, 3, 'h90, 'h40, -50, 60);  // large operands, clips both ways
    tests[4] = make_cfg(1 + $urandom % 4, 1 + $urandom % 6, $urandom % 256, $urandom % 256,
                        -int'($urandom % 100), $urandom % 100);
    cycle_limit = 0;
    foreach (tests[t]) begin
      cycle_limit += int'(tests[t].num_iters) * int'(tests[t].num_reads_per_iter) * 4 + 40;
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    load_memories();
    foreach (tests[t]) begin
      run_test(tests[t]);
    end
    chk_errs = rtlinf_top_inst.rtlinf_checker_inst.fail_cnt;
    $display("errors: %0d value, %0d protocol, %0d checker", value_errs, proto_errs, chk_errs);
    if (value_errs + proto_errs + chk_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- rtlinf_checker.sv
// rtlinf protocol checker
// bound into rtlinf_top, watches reset values, done and write addresses
module rtlinf_checker (
  input logic                                   clk,
  input logic                                   rst_n,
  input logic                                   write_valid,
  input logic [rtlinf_pkg::LOG_MAX_ADDRESS-1:0] write_addr,
  input logic                                   done
);

  int fail_cnt = 0;  // read by the testbench

  quiet_in_reset: assert property (@(posedge clk) !rst_n |=> (!write_valid && !done))
    else begin
      fail_cnt++;
      $error("write_valid or done high during reset");
    end

  // done rides on the final write and the cycle after it is quiet
  done_with_write: assert property (@(posedge clk) disable iff (!rst_n)
      (done || $past(done)) |-> (write_valid == !$past(done)))
    else begin
      fail_cnt++;
      $error("done without write_valid, or a write right after done");
    end

  // back to back writes step the address by one
  addr_step: assert property (@(posedge clk) disable iff (!rst_n)
      (write_valid && $past(write_valid)) |-> (write_addr == $past(write_addr) + 1'b1))
    else begin
      fail_cnt++;
      $error("write_addr did not advance by one");
    end

endmodule

bind rtlinf_top rtlinf_checker rtlinf_checker_inst (
  .clk(clk), .rst_n(rst_n), .write_valid(write_valid), .write_addr(write_addr), .done(done)
);

//--- rtlinf_top.sv
// rtlinf top level
// activation and weight memories, lockstep readers, operand join,
// mac lanes, lane drain and clip writer
module rtlinf_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   configure,
  input  rtlinf_pkg::rtlinf_cfg_t                cfg,
  input  rtlinf_pkg::mem_load_t                  load,
  output logic                                   write_valid,
  output logic [rtlinf_pkg::LOG_MAX_ADDRESS-1:0] write_addr,
  output logic [rtlinf_pkg::ACT_WORD_WIDTH-1:0]  write_data,
  output logic                                   done
);

  logic                                     act_load_en, weight_load_en;
  logic                                     act_read, act_mem_valid;
  logic [rtlinf_pkg::LOG_MAX_ADDRESS-1:0]   act_addr;
  logic [rtlinf_pkg::ACT_WORD_WIDTH-1:0]    act_mem_data;
  logic                                     weight_read, weight_mem_valid;
  logic [rtlinf_pkg::LOG_MAX_ADDRESS-1:0]   weight_addr;
  logic [rtlinf_pkg::WEIGHT_WORD_WIDTH-1:0] weight_mem_data;
  logic                                     act_valid, act_avail;
  logic [rtlinf_pkg::ACT_WORD_WIDTH-1:0]    act_data;
  logic                                     weight_valid, weight_avail;
  logic [rtlinf_pkg::WEIGHT_WORD_WIDTH-1:0] weight_data;
  logic                                     op_valid;
  logic [rtlinf_pkg::ACT_WORD_WIDTH-1:0]    op_act;
  logic [rtlinf_pkg::WEIGHT_WORD_WIDTH-1:0] op_weight;
  logic [rtlinf_pkg::NUM_LANES-1:0]         lane_avail, lane_result_valid;
  rtlinf_pkg::lane_sum_t                    lane_results [rtlinf_pkg::NUM_LANES];
  logic                                     take, sum_valid;
  rtlinf_pkg::lane_sum_t                    sum;

  assign act_load_en    = load.load_en && !load.load_weight;
  assign weight_load_en = load.load_en && load.load_weight;

  tile_mem #(.WIDTH(rtlinf_pkg::ACT_WORD_WIDTH)) act_mem_m (
    .clk(clk), .rst_n(rst_n), .load_en(act_load_en), .load_addr(load.load_addr),
    .load_data(load.load_data[rtlinf_pkg::ACT_WORD_WIDTH-1:0]),
    .read(act_read), .addr(act_addr), .data(act_mem_data), .valid_out(act_mem_valid)
  );

  tile_mem #(.WIDTH(rtlinf_pkg::WEIGHT_WORD_WIDTH)) weight_mem_m (
    .clk(clk), .rst_n(rst_n), .load_en(weight_load_en), .load_addr(load.load_addr),
    .load_data(load.load_data), .read(weight_read), .addr(weight_addr),
    .data(weight_mem_data), .valid_out(weight_mem_valid)
  );

  stream_reader #(.WIDTH(rtlinf_pkg::ACT_WORD_WIDTH)) act_reader_m (
    .clk(clk), .rst_n(rst_n), .configure(configure), .cfg(cfg),
    .read(act_read), .addr(act_addr), .mem_data(act_mem_data), .mem_valid(act_mem_valid),
    .valid(act_valid), .data(act_data), .avail(act_avail)
  );

  stream_reader #(.WIDTH(rtlinf_pkg::WEIGHT_WORD_WIDTH)) weight_reader_m (
    .clk(clk), .rst_n(rst_n), .configure(configure), .cfg(cfg),
    .read(weight_read), .addr(weight_addr), .mem_data(weight_mem_data),
    .mem_valid(weight_mem_valid), .valid(weight_valid), .data(weight_data),
    .avail(weight_avail)
  );

  operand_join operand_join_m (
    .act_valid(act_valid), .act_data(act_data), .act_avail(act_avail),
    .weight_valid(weight_valid), .weight_data(weight_data), .weight_avail(weight_avail),
    .lane_avail(lane_avail), .op_valid(op_valid), .op_act(op_act), .op_weight(op_weight)
  );

  for (genvar l = 0; l < rtlinf_pkg::NUM_LANES; l++) begin : g_lane
    mac_lane mac_lane_m (
      .clk(clk), .rst_n(rst_n), .configure(configure), .cfg(cfg),
      .lane_weight(op_weight[l*rtlinf_pkg::DATA_WIDTH +: rtlinf_pkg::DATA_WIDTH]),
      .op_valid(op_valid), .op_act(op_act), .lane_avail(lane_avail[l]),
      .result_valid(lane_result_valid[l]), .result(lane_results[l]), .take(take)
    );
  end

  lane_drain lane_drain_m (
    .clk(clk), .rst_n(rst_n), .result_valid(lane_result_valid), .results(lane_results),
    .take(take), .sum_valid(sum_valid), .sum(sum)
  );

  clip_writer clip_writer_m (
    .clk(clk), .rst_n(rst_n), .configure(configure), .cfg(cfg),
    .sum_valid(sum_valid), .sum(sum), .write_valid(write_valid),
    .write_addr(write_addr), .write_data(write_data), .done(done)
  );

endmodule

//--- clip_writer.sv
// clip writer
// saturates each sum to min_clip..max_clip, emits it with its address
// and pulses done with the last write of the run
module clip_writer (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   configure,
  input  rtlinf_pkg::rtlinf_cfg_t                cfg,
  input  logic                                   sum_valid,
  input  rtlinf_pkg::lane_sum_t                  sum,
  output logic                                   write_valid,
  output logic [rtlinf_pkg::LOG_MAX_ADDRESS-1:0] write_addr,
  output logic [rtlinf_pkg::ACT_WORD_WIDTH-1:0]  write_data,
  output logic                                   done
);

  logic signed [rtlinf_pkg::DATA_WIDTH-1:0]  min_clip;
  logic signed [rtlinf_pkg::DATA_WIDTH-1:0]  max_clip;
  logic [rtlinf_pkg::LOG_MAX_ADDRESS-1:0]    addr_cnt;
  logic [rtlinf_pkg::TOTAL_WIDTH-1:0]        total;
  logic [rtlinf_pkg::TOTAL_WIDTH-1:0]        write_cnt;
  logic signed [rtlinf_pkg::ACC_WIDTH-1:0]   s;
  logic [rtlinf_pkg::ACT_WORD_WIDTH-1:0]     clipped;

  always_comb begin
    for (int g = 0; g < rtlinf_pkg::GROUP_SIZE; g++) begin
      s = sum.sums[g];
      if (s > max_clip) begin
        clipped[g*rtlinf_pkg::DATA_WIDTH +: rtlinf_pkg::DATA_WIDTH] = max_clip;
      end else if (s < min_clip) begin
        clipped[g*rtlinf_pkg::DATA_WIDTH +: rtlinf_pkg::DATA_WIDTH] = min_clip;
      end else begin
        clipped[g*rtlinf_pkg::DATA_WIDTH +: rtlinf_pkg::DATA_WIDTH] =
          s[rtlinf_pkg::DATA_WIDTH-1:0];  // in range, fits in a byte
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      write_valid <= 1'b0;
      done        <= 1'b0;
      min_clip    <= '0;
      max_clip    <= '0;
      addr_cnt    <= '0;
      total       <= '0;
      write_cnt   <= '0;
    end else begin
      write_valid <= sum_valid;
      done        <= sum_valid && (write_cnt == total - 1'b1);
      if (configure) begin
        min_clip  <= cfg.min_clip;
        max_clip  <= cfg.max_clip;
        addr_cnt  <= cfg.write_address;
        total     <= rtlinf_pkg::TOTAL_WIDTH'(cfg.num_iters) *
                     rtlinf_pkg::TOTAL_WIDTH'(rtlinf_pkg::NUM_LANES);
        write_cnt <= '0;
      end else if (sum_valid) begin
        addr_cnt  <= addr_cnt + 1'b1;
        write_cnt <= write_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sum_valid) begin
      write_addr <= addr_cnt;
      write_data <= clipped;
    end
  end

endmodule

//--- lane_drain.sv
// lane drain
// waits for every lane, then sends the lane sums one per cycle
// in lane order and releases the lanes on the last one
module lane_drain (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [rtlinf_pkg::NUM_LANES-1:0] result_valid,
  input  rtlinf_pkg::lane_sum_t            results [rtlinf_pkg::NUM_LANES],
  output logic                             take,
  output logic                             sum_valid,
  output rtlinf_pkg::lane_sum_t            sum
);

  rtlinf_pkg::drain_state_e                state;
  logic [rtlinf_pkg::LANE_IDX_WIDTH-1:0]   lane_cnt;
  logic                                    last_lane;

  assign last_lane = (lane_cnt == rtlinf_pkg::LANE_IDX_WIDTH'(rtlinf_pkg::NUM_LANES - 1));
  assign sum_valid = (state == rtlinf_pkg::DR_SEND);
  assign sum       = results[lane_cnt];  // lanes hold their sums until take
  assign take      = sum_valid && last_lane;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= rtlinf_pkg::DR_COLLECT;
      lane_cnt <= '0;
    end else begin
      case (state)
        rtlinf_pkg::DR_COLLECT: begin
          lane_cnt <= '0;
          if (&result_valid) begin
            state <= rtlinf_pkg::DR_SEND;
          end
        end
        rtlinf_pkg::DR_SEND: begin
          lane_cnt <= lane_cnt + 1'b1;
          if (last_lane) begin
            state <= rtlinf_pkg::DR_COLLECT;
          end
        end
        default: state <= rtlinf_pkg::DR_COLLECT;
      endcase
    end
  end

endmodule

//--- mac_lane.sv
// multiply-accumulate lane
// multiplies its weight byte by each activation of the group and
// accumulates over one iteration, holding the sums until take
module mac_lane (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  configure,
  input  rtlinf_pkg::rtlinf_cfg_t               cfg,
  input  logic [rtlinf_pkg::DATA_WIDTH-1:0]     lane_weight,
  input  logic                                  op_valid,
  input  logic [rtlinf_pkg::ACT_WORD_WIDTH-1:0] op_act,
  output logic                                  lane_avail,
  output logic                                  result_valid,
  output rtlinf_pkg::lane_sum_t                 result,
  input  logic                                  take
);

  logic [rtlinf_pkg::LOG_MAX_READS_PER_ITER-1:0] reads_per_iter;
  logic [rtlinf_pkg::LOG_MAX_READS_PER_ITER-1:0] read_cnt;
  logic signed [rtlinf_pkg::DATA_WIDTH-1:0]      w_s;
  logic signed [rtlinf_pkg::DATA_WIDTH-1:0]      act_b [rtlinf_pkg::GROUP_SIZE];
  logic signed [rtlinf_pkg::ACC_WIDTH-1:0]       prod  [rtlinf_pkg::GROUP_SIZE];
  logic                                          xfer;

  assign lane_avail = !result_valid;  // busy while a result waits
  assign xfer       = op_valid && lane_avail;
  assign w_s        = lane_weight;

  always_comb begin
    for (int g = 0; g < rtlinf_pkg::GROUP_SIZE; g++) begin
      act_b[g] = op_act[g*rtlinf_pkg::DATA_WIDTH +: rtlinf_pkg::DATA_WIDTH];
      prod[g]  = act_b[g] * w_s;  // sign extended to ACC_WIDTH first
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reads_per_iter <= '0;
      read_cnt       <= '0;
      result_valid   <= 1'b0;
      result         <= '0;
    end else begin
      if (configure) begin
        reads_per_iter <= cfg.num_reads_per_iter;
      end
      if (take) begin
        result_valid <= 1'b0;
        result       <= '0;
      end else if (xfer) begin
        for (int g = 0; g < rtlinf_pkg::GROUP_SIZE; g++) begin
          result.sums[g] <= result.sums[g] + prod[g];  // wraps at 16 bits
        end
        if (read_cnt == reads_per_iter - 1'b1) begin
          read_cnt     <= '0;
          result_valid <= 1'b1;
        end else begin
          read_cnt <= read_cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- operand_join.sv
// operand join
// pairs activation and weight words and broadcasts them to every lane
module operand_join (
  input  logic                                     act_valid,
  input  logic [rtlinf_pkg::ACT_WORD_WIDTH-1:0]    act_data,
  output logic                                     act_avail,
  input  logic                                     weight_valid,
  input  logic [rtlinf_pkg::WEIGHT_WORD_WIDTH-1:0] weight_data,
  output logic                                     weight_avail,
  input  logic [rtlinf_pkg::NUM_LANES-1:0]         lane_avail,
  output logic                                     op_valid,
  output logic [rtlinf_pkg::ACT_WORD_WIDTH-1:0]    op_act,
  output logic [rtlinf_pkg::WEIGHT_WORD_WIDTH-1:0] op_weight
);

  logic lanes_ready;

  assign lanes_ready = &lane_avail;  // every lane must take the word

  assign op_valid = act_valid && weight_valid && lanes_ready;
  assign op_act    = act_data;
  assign op_weight = weight_data;

  // both readers pop together
  assign act_avail    = weight_valid && lanes_ready;
  assign weight_avail = act_valid && lanes_ready;

endmodule

//--- stream_reader.sv
// stream reader
// walks num_iters*num_reads_per_iter words from read_address,
// one read in flight, results held in a one-entry output register
module stream_reader #(
  parameter int WIDTH = 16
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   configure,
  input  rtlinf_pkg::rtlinf_cfg_t                cfg,
  output logic                                   read,
  output logic [rtlinf_pkg::LOG_MAX_ADDRESS-1:0] addr,
  input  logic [WIDTH-1:0]                       mem_data,
  input  logic                                   mem_valid,
  output logic                                   valid,
  output logic [WIDTH-1:0]                       data,
  input  logic                                   avail
);

  rtlinf_pkg::reader_state_e            state;
  logic [rtlinf_pkg::TOTAL_WIDTH-1:0]   remaining;

  // issue only with the register free or draining this cycle
  assign read = (state == rtlinf_pkg::RD_REQ) && (!valid || avail);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= rtlinf_pkg::RD_IDLE;
      valid     <= 1'b0;
      remaining <= '0;
      addr      <= '0;
    end else begin
      if (mem_valid) begin
        valid <= 1'b1;
      end else if (valid && avail) begin
        valid <= 1'b0;
      end

      case (state)
        rtlinf_pkg::RD_IDLE: begin
          if (configure) begin
            addr      <= cfg.read_address;
            remaining <= cfg.num_iters * cfg.num_reads_per_iter;
            state     <= rtlinf_pkg::RD_REQ;
          end
        end
        rtlinf_pkg::RD_REQ: begin
          if (read) begin
            state <= rtlinf_pkg::RD_WAIT;
          end
        end
        rtlinf_pkg::RD_WAIT: begin
          if (mem_valid) begin
            addr      <= addr + 1'b1;
            remaining <= remaining - 1'b1;
            state     <= (remaining == 1) ? rtlinf_pkg::RD_IDLE : rtlinf_pkg::RD_REQ;
          end
        end
        default: state <= rtlinf_pkg::RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (mem_valid) begin
      data <= mem_data;
    end
  end

endmodule

//--- tile_mem.sv
// tile memory
// written through the load port, read with one cycle of latency
module tile_mem #(
  parameter int WIDTH = 16
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   load_en,
  input  logic [rtlinf_pkg::LOG_MAX_ADDRESS-1:0] load_addr,
  input  logic [WIDTH-1:0]                       load_data,
  input  logic                                   read,
  input  logic [rtlinf_pkg::LOG_MAX_ADDRESS-1:0] addr,
  output logic [WIDTH-1:0]                       data,
  output logic                                   valid_out
);

  logic [WIDTH-1:0] mem [rtlinf_pkg::NUM_ADDRESSES];

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
    if (read) begin
      data <= mem[addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= read;  // data lands with this
    end
  end

endmodule

//--- rtlinf_pkg.sv
// rtlinf shared definitions
// sizes, config and load structs, lane result word and FSM states
package rtlinf_pkg;

  localparam int DATA_WIDTH             = 8;
  localparam int GROUP_SIZE             = 2;   // activations per activation word
  localparam int NUM_LANES              = 4;   // also weights per weight word
  localparam int ACC_WIDTH              = 16;
  localparam int LOG_MAX_ITERS          = 8;
  localparam int LOG_MAX_READS_PER_ITER = 8;
  localparam int LOG_MAX_ADDRESS        = 8;
  localparam int NUM_ADDRESSES          = 256;
  localparam int ACT_WORD_WIDTH         = GROUP_SIZE * DATA_WIDTH;
  localparam int WEIGHT_WORD_WIDTH      = NUM_LANES * DATA_WIDTH;
  localparam int TOTAL_WIDTH            = LOG_MAX_ITERS + LOG_MAX_READS_PER_ITER;
  localparam int LANE_IDX_WIDTH         = $clog2(NUM_LANES);

  typedef struct packed {
    logic [LOG_MAX_ITERS-1:0]          num_iters;
    logic [LOG_MAX_READS_PER_ITER-1:0] num_reads_per_iter;
    logic [LOG_MAX_ADDRESS-1:0]        read_address;
    logic [LOG_MAX_ADDRESS-1:0]        write_address;
    logic signed [DATA_WIDTH-1:0]      min_clip;
    logic signed [DATA_WIDTH-1:0]      max_clip;
  } rtlinf_cfg_t;

  typedef struct packed {
    logic                         load_en;
    logic                         load_weight;  // 1 selects the weight memory
    logic [LOG_MAX_ADDRESS-1:0]   load_addr;
    logic [WEIGHT_WORD_WIDTH-1:0] load_data;    // activation memory takes the low bits
  } mem_load_t;

  // sums[g] belongs to group element g
  typedef struct packed {
    logic [GROUP_SIZE-1:0][ACC_WIDTH-1:0] sums;
  } lane_sum_t;

  typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_WAIT} reader_state_e;

  typedef enum logic {DR_COLLECT, DR_SEND} drain_state_e;

endpackage
